// ==== hw/noc_pkg.sv ====
package noc_pkg;

    // router geometry
    localparam int P      = 5; // local + four mesh neighbours
    localparam int V      = 2; // virtual channels per port
    localparam int FW     = 32;
    localparam int PORT_W = 3;

    // flit layout, header and tail flags on top
    localparam int FLIT_HDR_BIT  = 31;
    localparam int FLIT_TAIL_BIT = 30;
    localparam int FLIT_VC_LSB   = 28; // one-hot vc, V bits
    localparam int FLIT_DST_LSB  = 25; // port code, PORT_W bits

    typedef enum logic [PORT_W-1:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_SOUTH = 3'd4
    } port_e;

    typedef logic [P-1:0] port_vec_t; // one bit per port
    typedef logic [V-1:0] vc_vec_t;   // one bit per vc

    // opposite side of the router
    // local maps onto itself and marks the port as having no partner
    function automatic port_e straight_port(input port_e port);
        case (port)
            PORT_EAST: begin
                return PORT_WEST;
            end
            PORT_WEST: begin
                return PORT_EAST;
            end
            PORT_NORTH: begin
                return PORT_SOUTH;
            end
            PORT_SOUTH: begin
                return PORT_NORTH;
            end
            default: begin
                return PORT_LOCAL;
            end
        endcase
    endfunction

endpackage

// ==== hw/ssa_cfg_pkg.sv ====
package ssa_cfg_pkg;

    // apb side of the bypass register block
    localparam int CSR_AW = 4;
    localparam int CSR_DW = 32;

    localparam int CNT_W  = 16; // bypass counter, wraps
    localparam int GCNT_W = 3;  // grants per cycle, 0 to 4

    typedef enum logic [CSR_AW-1:0] {
        REG_EN  = 4'h0, // per-port bypass enable
        REG_CNT = 4'h4  // bypassed flit count, write clears
    } ssa_reg_e;

    // every port except local starts enabled
    localparam noc_pkg::port_vec_t EN_RESET =
        ~(noc_pkg::port_vec_t'(1) << noc_pkg::PORT_LOCAL);

endpackage

// ==== hw/ssa_flit_decode.sv ====
`timescale 1ns/10ps

module ssa_flit_decode (
    input  logic [noc_pkg::FW-1:0] flit_i,
    input  logic                   flit_wr_i,
    output logic                   hdr_o,
    output logic                   tail_o,
    output noc_pkg::vc_vec_t       vc_o,
    output noc_pkg::port_e         dest_o,
    output logic                   single_o
);
    import noc_pkg::*;

    logic hdr_flag;
    logic tail_flag;
    logic [PORT_W-1:0] dest_code;

    // raw fields
    assign hdr_flag  = flit_i[FLIT_HDR_BIT];
    assign tail_flag = flit_i[FLIT_TAIL_BIT];
    assign dest_code = flit_i[FLIT_DST_LSB +: PORT_W];

    // flags only count on a real write
    assign hdr_o  = flit_wr_i & hdr_flag;
    assign tail_o = flit_wr_i & tail_flag;

    assign vc_o   = flit_i[FLIT_VC_LSB +: V]; // one-hot
    assign dest_o = port_e'(dest_code);      // meaningful on headers only

    // header carrying the tail flag as well
    assign single_o = hdr_o & tail_o;

endmodule

// ==== hw/ssa_vc_slice.sv ====
`timescale 1ns/10ps

module ssa_vc_slice #(
    parameter noc_pkg::port_e IN_PORT = noc_pkg::PORT_WEST,
    parameter int             VC_ID   = 0
) (
    input  logic                   flit_wr_i,
    input  logic [noc_pkg::FW-1:0] flit_i,
    input  logic                   bypass_en_i,
    input  logic                   ivc_req_i,
    input  logic                   ovc_is_assigned_i,
    input  noc_pkg::vc_vec_t       assigned_ovc_i,
    input  noc_pkg::port_e         ivc_dest_i,
    input  logic                   ss_ovc_avail_i,
    input  logic                   ss_ovc_full_i,
    input  logic                   ss_ovc_granted_i,
    input  logic                   in_sw_granted_i,
    output logic                   sw_grant_o,
    output logic                   ovc_grant_o,
    output logic                   ivc_reset_o,
    output logic                   credit_dec_o,
    output logic                   ovc_allocated_o,
    output logic                   ovc_released_o
);
    import noc_pkg::*;

    localparam port_e SS_PORT = straight_port(IN_PORT);
    localparam bit    SS_EN   = (SS_PORT != PORT_LOCAL); // local never bypasses

    logic    hdr;
    logic    tail;
    logic    single;
    vc_vec_t vc_in;
    port_e   dest_in;

    logic no_port_grant;
    logic ss_hdr;       // incoming header heads straight
    logic ss_nonhdr;    // buffered packet heads straight
    logic assigned_ready;
    logic ss_ovc_ready;
    logic permit;
    logic vc_wr;
    logic credit_pre;
    logic alloc_pre;
    logic release_pre;

    ssa_flit_decode u_decode (
        .flit_i   (flit_i),
        .flit_wr_i(flit_wr_i),
        .hdr_o    (hdr),
        .tail_o   (tail),
        .vc_o     (vc_in),
        .dest_o   (dest_in),
        .single_o (single)
    );

    assign ss_hdr    = (dest_in == SS_PORT);
    assign ss_nonhdr = (ivc_dest_i == SS_PORT);

    // nothing granted at this input or at the straight output
    assign no_port_grant = ~(ss_ovc_granted_i | in_sw_granted_i);

    // body and tail flits must already own the matching straight vc
    assign assigned_ready = ss_nonhdr & assigned_ovc_i[VC_ID] & ~ss_ovc_full_i;
    assign ss_ovc_ready   = ovc_is_assigned_i ? assigned_ready : ss_ovc_avail_i;

    assign permit = SS_EN & bypass_en_i & ~ivc_req_i & no_port_grant & ss_ovc_ready;

    assign vc_wr = flit_wr_i & vc_in[VC_ID];

    // a header bound elsewhere is left to the normal pipeline
    assign credit_pre  = ~(hdr & ~ss_hdr);
    assign alloc_pre   = hdr & ss_hdr;
    assign release_pre = single ? credit_pre : tail;

    assign credit_dec_o = credit_pre & vc_wr & permit;
    assign sw_grant_o   = credit_dec_o;
    assign ovc_grant_o  = alloc_pre & vc_wr & permit;
    assign ivc_reset_o  = release_pre & vc_wr & permit;

    // single-flit packets never hold the output vc
    assign ovc_allocated_o = ovc_grant_o & ~single;
    assign ovc_released_o  = ivc_reset_o & ~single;

    // a header only ever claims a free straight vc
    a_alloc_free_ovc: assert final (!ovc_allocated_o || (ovc_grant_o && ss_ovc_avail_i))
        else $error("ovc allocated on a busy vc on port %0d vc %0d", IN_PORT, VC_ID);

endmodule

// ==== hw/ssa_csr.sv ====
`timescale 1ns/10ps

module ssa_csr (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [ssa_cfg_pkg::CSR_AW-1:0] paddr_i,
    input  logic [ssa_cfg_pkg::CSR_DW-1:0] pwdata_i,
    output logic [ssa_cfg_pkg::CSR_DW-1:0] prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  logic [ssa_cfg_pkg::GCNT_W-1:0] grant_count_i,
    output noc_pkg::port_vec_t             bypass_en_o
);
    import noc_pkg::*;
    import ssa_cfg_pkg::*;

    ssa_reg_e         reg_sel;
    logic             reg_hit;
    logic             access;
    logic             wr_en;
    logic             rd_en;
    logic             cnt_clr;
    port_vec_t        en_q;
    logic [CNT_W-1:0] cnt_q;

    assign reg_sel = ssa_reg_e'(paddr_i);

    always_comb begin
        case (reg_sel)
            REG_EN, REG_CNT: reg_hit = 1'b1;
            default:         reg_hit = 1'b0; // unmapped
        endcase
    end

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i & reg_hit;
    assign rd_en  = access & ~pwrite_i & reg_hit;

    // no wait states
    assign pready_o  = access;
    assign pslverr_o = access & ~reg_hit;

    always_comb begin
        prdata_o = '0;
        if (rd_en) begin
            case (reg_sel)
                REG_EN:  prdata_o = CSR_DW'(en_q);
                REG_CNT: prdata_o = CSR_DW'(cnt_q);
                default: prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            en_q <= EN_RESET;
        end else if (wr_en && reg_sel == REG_EN) begin
            en_q <= pwdata_i[P-1:0];
        end
    end

    assign cnt_clr = wr_en & (reg_sel == REG_CNT);

    // clear still takes this cycle's grants
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (cnt_clr) begin
            cnt_q <= CNT_W'(grant_count_i);
        end else begin
            cnt_q <= cnt_q + CNT_W'(grant_count_i); // wraps at CNT_W
        end
    end

    assign bypass_en_o = en_q;

    // slave error only in an access phase that followed a setup phase
    a_slverr_access: assert property (@(posedge clk) disable iff (reset_i)
        pslverr_o |-> penable_i && $past(psel_i && !penable_i));

endmodule

// ==== hw/ssa_allocator.sv ====
`timescale 1ns/10ps

module ssa_allocator (
    input  logic                           clk,
    input  logic                           reset_i,
    // flit inputs
    input  noc_pkg::port_vec_t             flit_in_wr_i,
    input  logic [noc_pkg::FW-1:0]         flit_in_i         [noc_pkg::P],
    // router state
    input  noc_pkg::port_vec_t             any_ovc_granted_i,
    input  noc_pkg::port_vec_t             any_sw_granted_i,
    input  noc_pkg::vc_vec_t               ivc_req_i         [noc_pkg::P],
    input  noc_pkg::vc_vec_t               ovc_is_assigned_i [noc_pkg::P],
    input  noc_pkg::vc_vec_t               assigned_ovc_i    [noc_pkg::P][noc_pkg::V],
    input  noc_pkg::port_e                 ivc_dest_i        [noc_pkg::P][noc_pkg::V],
    input  noc_pkg::vc_vec_t               ovc_avail_i       [noc_pkg::P],
    input  noc_pkg::vc_vec_t               ovc_full_i        [noc_pkg::P],
    // per input port
    output noc_pkg::vc_vec_t               ivc_sw_grant_o    [noc_pkg::P],
    output noc_pkg::vc_vec_t               ivc_ovc_grant_o   [noc_pkg::P],
    output noc_pkg::vc_vec_t               ivc_reset_o       [noc_pkg::P],
    // per output port
    output noc_pkg::vc_vec_t               ovc_allocated_o   [noc_pkg::P],
    output noc_pkg::vc_vec_t               ovc_released_o    [noc_pkg::P],
    output noc_pkg::vc_vec_t               credit_dec_o      [noc_pkg::P],
    output noc_pkg::port_vec_t             ssa_flit_wr_o,
    // apb
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [ssa_cfg_pkg::CSR_AW-1:0] paddr_i,
    input  logic [ssa_cfg_pkg::CSR_DW-1:0] pwdata_i,
    output logic [ssa_cfg_pkg::CSR_DW-1:0] prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o
);
    import noc_pkg::*;
    import ssa_cfg_pkg::*;

    port_vec_t         bypass_en;
    port_vec_t         sw_any;     // some vc of this input bypassed
    logic [GCNT_W-1:0] grant_cnt;

    ssa_csr u_csr (
        .clk          (clk),
        .reset_i      (reset_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .grant_count_i(grant_cnt),
        .bypass_en_o  (bypass_en)
    );

    for (genvar ip = 0; ip < P; ip++) begin : g_port
        localparam port_e SS_PORT = straight_port(port_e'(ip));

        if (SS_PORT == PORT_LOCAL) begin : g_off
            // no partner, and by symmetry nobody targets this output either
            assign ivc_sw_grant_o[ip]  = '0;
            assign ivc_ovc_grant_o[ip] = '0;
            assign ivc_reset_o[ip]     = '0;
            assign ovc_allocated_o[ip] = '0;
            assign ovc_released_o[ip]  = '0;
            assign credit_dec_o[ip]    = '0;
        end else begin : g_ss
            for (genvar v = 0; v < V; v++) begin : g_vc
                ssa_vc_slice #(
                    .IN_PORT(port_e'(ip)),
                    .VC_ID  (v)
                ) u_slice (
                    .flit_wr_i        (flit_in_wr_i[ip]),
                    .flit_i           (flit_in_i[ip]),
                    .bypass_en_i      (bypass_en[ip]),
                    .ivc_req_i        (ivc_req_i[ip][v]),
                    .ovc_is_assigned_i(ovc_is_assigned_i[ip][v]),
                    .assigned_ovc_i   (assigned_ovc_i[ip][v]),
                    .ivc_dest_i       (ivc_dest_i[ip][v]),
                    .ss_ovc_avail_i   (ovc_avail_i[SS_PORT][v]),
                    .ss_ovc_full_i    (ovc_full_i[SS_PORT][v]),
                    .ss_ovc_granted_i (any_ovc_granted_i[SS_PORT]),
                    .in_sw_granted_i  (any_sw_granted_i[ip]),
                    .sw_grant_o       (ivc_sw_grant_o[ip][v]),
                    .ovc_grant_o      (ivc_ovc_grant_o[ip][v]),
                    .ivc_reset_o      (ivc_reset_o[ip][v]),
                    .credit_dec_o     (credit_dec_o[SS_PORT][v]),
                    .ovc_allocated_o  (ovc_allocated_o[SS_PORT][v]),
                    .ovc_released_o   (ovc_released_o[SS_PORT][v])
                );
            end
        end

        assign sw_any[ip] = |ivc_sw_grant_o[ip];

        // slices of one input must not both win
        a_sw_onehot: assert property (@(posedge clk) disable iff (reset_i)
            $onehot0(ivc_sw_grant_o[ip]));
    end

    always_comb begin
        grant_cnt = '0;
        for (int p = 0; p < P; p++) begin
            grant_cnt = grant_cnt + GCNT_W'(sw_any[p]);
        end
    end

    // flit leaves on the opposite port one cycle after its grant
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ssa_flit_wr_o <= '0;
        end else begin
            for (int o = 0; o < P; o++) begin
                ssa_flit_wr_o[o] <= sw_any[straight_port(port_e'(o))];
            end
        end
    end

endmodule

// ==== dv/ssa_tb_checks.svh ====
`ifndef SSA_TB_CHECKS_SVH
`define SSA_TB_CHECKS_SVH

// first failure ends the run
task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "testbench stopped at %0t", $time);
endtask

task automatic check_port_vec(input string name, input port_vec_t exp, input port_vec_t got);
    if (got !== exp) begin
        fail_run($sformatf("ERROR %s expected 0x%h got 0x%h at %0t", name, exp, got, $time));
    end
endtask

// per-port vc vectors, index shown next to the name
task automatic check_vc_vec(input string name, input int port, input vc_vec_t exp,
                            input vc_vec_t got);
    if (got !== exp) begin
        fail_run($sformatf("ERROR %s[%0d] expected 0x%h got 0x%h at %0t",
                           name, port, exp, got, $time));
    end
endtask

task automatic check_word(input string name, input logic [CSR_DW-1:0] exp,
                          input logic [CSR_DW-1:0] got);
    if (got !== exp) begin
        fail_run($sformatf("ERROR %s expected 0x%h got 0x%h at %0t", name, exp, got, $time));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        fail_run($sformatf("ERROR %s expected 0x%h got 0x%h at %0t", name, exp, got, $time));
    end
endtask

`endif

// ==== dv/tb_ssa_allocator.sv ====
`timescale 1ns/10ps

module tb_ssa_allocator;
    import noc_pkg::*;
    import ssa_cfg_pkg::*;

    localparam int    RESET_CYCLES = 10;
    localparam int    NUM_FIELDS   = 24;
    localparam string TRACE_FILE   = "dv/ssa_trace.txt";

    logic              clk;
    logic              reset_i;
    port_vec_t         flit_in_wr;
    logic [FW-1:0]     flit_in         [P];
    port_vec_t         any_ovc_granted;
    port_vec_t         any_sw_granted;
    vc_vec_t           ivc_req         [P];
    vc_vec_t           ovc_is_assigned [P];
    vc_vec_t           assigned_ovc    [P][V];
    port_e             ivc_dest        [P][V];
    vc_vec_t           ovc_avail       [P];
    vc_vec_t           ovc_full        [P];
    vc_vec_t           ivc_sw_grant    [P];
    vc_vec_t           ivc_ovc_grant   [P];
    vc_vec_t           ivc_reset       [P];
    vc_vec_t           ovc_allocated   [P];
    vc_vec_t           ovc_released    [P];
    vc_vec_t           credit_dec      [P];
    port_vec_t         ssa_flit_wr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [CSR_AW-1:0] paddr;
    logic [CSR_DW-1:0] pwdata;
    logic [CSR_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    string rows[$];
    int    cycles;
    int    cycle_limit;

    // fields of the row being applied
    logic [31:0] in_port, out_port, wr, flit, ogr, sgr;
    logic [31:0] req, asg, aovc, dst, avl, ful, apb, addr, wdata;
    logic [31:0] exp_sw, exp_og, exp_rst, exp_cr, exp_al, exp_rl, exp_fwr, exp_rd, exp_err;

    `include "ssa_tb_checks.svh"

    ssa_allocator u_dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .flit_in_wr_i     (flit_in_wr),
        .flit_in_i        (flit_in),
        .any_ovc_granted_i(any_ovc_granted),
        .any_sw_granted_i (any_sw_granted),
        .ivc_req_i        (ivc_req),
        .ovc_is_assigned_i(ovc_is_assigned),
        .assigned_ovc_i   (assigned_ovc),
        .ivc_dest_i       (ivc_dest),
        .ovc_avail_i      (ovc_avail),
        .ovc_full_i       (ovc_full),
        .ivc_sw_grant_o   (ivc_sw_grant),
        .ivc_ovc_grant_o  (ivc_ovc_grant),
        .ivc_reset_o      (ivc_reset),
        .ovc_allocated_o  (ovc_allocated),
        .ovc_released_o   (ovc_released),
        .credit_dec_o     (credit_dec),
        .ssa_flit_wr_o    (ssa_flit_wr),
        .psel_i           (psel),
        .penable_i        (penable),
        .pwrite_i         (pwrite),
        .paddr_i          (paddr),
        .pwdata_i         (pwdata),
        .prdata_o         (prdata),
        .pready_o         (pready),
        .pslverr_o        (pslverr)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin // skip blanks and notes
                    rows.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic parse_row(input string line);
        int n;
        n = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            in_port, out_port, wr, flit, ogr, sgr, req, asg, aovc, dst, avl, ful,
            apb, addr, wdata, exp_sw, exp_og, exp_rst, exp_cr, exp_al, exp_rl,
            exp_fwr, exp_rd, exp_err);
        if (n != NUM_FIELDS) begin
            fail_run($sformatf("trace row has %0d fields instead of %0d", n, NUM_FIELDS));
        end
    endtask

    // everything idle except the row's input and straight output
    task automatic drive_row();
        flit_in_wr      <= '0;
        any_ovc_granted <= ogr[P-1:0];
        any_sw_granted  <= sgr[P-1:0];
        for (int p = 0; p < P; p++) begin
            flit_in[p]         <= '0;
            ivc_req[p]         <= '0;
            ovc_is_assigned[p] <= '0;
            ovc_avail[p]       <= '0;
            ovc_full[p]        <= '0;
            for (int v = 0; v < V; v++) begin
                assigned_ovc[p][v] <= '0;
                ivc_dest[p][v]     <= PORT_LOCAL;
            end
        end
        flit_in_wr[in_port]         <= wr[0];
        flit_in[in_port]            <= flit;
        ivc_req[in_port]            <= req[V-1:0];
        ovc_is_assigned[in_port]    <= asg[V-1:0];
        assigned_ovc[in_port][0]    <= aovc[1:0];
        assigned_ovc[in_port][1]    <= aovc[3:2];
        ivc_dest[in_port][0]        <= port_e'(dst[2:0]);
        ivc_dest[in_port][1]        <= port_e'(dst[6:4]);
        ovc_avail[out_port]         <= avl[V-1:0];
        ovc_full[out_port]          <= ful[V-1:0];
        psel    <= apb[2];
        penable <= apb[1];
        pwrite  <= apb[0];
        paddr   <= addr[CSR_AW-1:0];
        pwdata  <= wdata;
    endtask

    function automatic vc_vec_t expected_at(input int p, input logic [31:0] sel,
                                            input logic [31:0] val);
        return (p == sel) ? val[V-1:0] : '0;
    endfunction

    task automatic check_row();
        for (int p = 0; p < P; p++) begin
            check_vc_vec("ivc_sw_grant_o", p, expected_at(p, in_port, exp_sw), ivc_sw_grant[p]);
            check_vc_vec("ivc_ovc_grant_o", p, expected_at(p, in_port, exp_og), ivc_ovc_grant[p]);
            check_vc_vec("ivc_reset_o", p, expected_at(p, in_port, exp_rst), ivc_reset[p]);
            check_vc_vec("credit_dec_o", p, expected_at(p, out_port, exp_cr), credit_dec[p]);
            check_vc_vec("ovc_allocated_o", p, expected_at(p, out_port, exp_al), ovc_allocated[p]);
            check_vc_vec("ovc_released_o", p, expected_at(p, out_port, exp_rl), ovc_released[p]);
        end
        check_port_vec("ssa_flit_wr_o", exp_fwr[P-1:0], ssa_flit_wr);
        check_flag("pready_o", psel & penable, pready); // no wait states
        check_flag("pslverr_o", exp_err[0], pslverr);
        if (psel && penable && !pwrite) begin
            check_word("prdata_o", exp_rd, prdata);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        clk             = 1'b0;
        reset_i         = 1'b1;
        cycles          = 0;
        cycle_limit     = 0;
        flit_in_wr      = '0;
        any_ovc_granted = '0;
        any_sw_granted  = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        for (int p = 0; p < P; p++) begin
            flit_in[p]         = '0;
            ivc_req[p]         = '0;
            ovc_is_assigned[p] = '0;
            ovc_avail[p]       = '0;
            ovc_full[p]        = '0;
            for (int v = 0; v < V; v++) begin
                assigned_ovc[p][v] = '0;
                ivc_dest[p][v]     = PORT_LOCAL;
            end
        end
        load_trace();
        cycle_limit = 2 * rows.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            parse_row(rows[i]);
            drive_row();
            @(negedge clk); // outputs settled mid-cycle
            check_row();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
hw/noc_pkg.sv
hw/ssa_cfg_pkg.sv
hw/ssa_flit_decode.sv
hw/ssa_vc_slice.sv
hw/ssa_csr.sv
hw/ssa_allocator.sv
dv/tb_ssa_allocator.sv

// ==== Bender.yml ====
package:
  name: ssa_allocator

sources:
  - hw/noc_pkg.sv
  - hw/ssa_cfg_pkg.sv
  - hw/ssa_flit_decode.sv
  - hw/ssa_vc_slice.sv
  - hw/ssa_csr.sv
  - hw/ssa_allocator.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_ssa_allocator.sv

// ==== dv/ssa_trace.txt ====
# in out wr flit ogr sgr req asg aovc(vc1,vc0) dst(vc1,vc0) avl ful apb{sel,en,wr} addr wdata
# then expected: sw og rst (at in) cr al rl (at out) flit_wr rdata slverr
0 0 0 00000000 00 00 0 0 0 00 0 0 4 0 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 6 0 00000000 0 0 0 0 0 0 00 0000001e 0
3 1 1 920000aa 00 00 0 0 0 00 1 0 0 0 00000000 1 1 0 1 1 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 0 0 00000000 0 0 0 0 0 0 02 00000000 0
3 1 1 920000aa 02 00 0 0 0 00 1 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0
3 1 1 920000aa 00 08 0 0 0 00 1 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0
3 1 1 920000aa 00 00 1 0 0 00 1 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0
2 4 1 96000000 00 00 0 0 0 00 1 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0
2 4 1 100000bb 00 00 0 1 1 04 0 0 0 0 00000000 1 0 0 1 0 0 00 00000000 0
2 4 1 500000cc 00 00 0 1 1 04 0 0 0 0 00000000 1 0 1 1 0 1 10 00000000 0
2 4 1 100000dd 00 00 0 1 1 04 0 1 0 0 00000000 0 0 0 0 0 0 10 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0
1 3 1 e60000ee 00 00 0 0 0 00 2 0 0 0 00000000 2 2 2 2 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 0 0 00000000 0 0 0 0 0 0 08 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 5 0 0000000e 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 7 0 0000000e 0 0 0 0 0 0 00 00000000 0
4 2 1 94000000 00 00 0 0 0 00 1 0 0 0 00000000 0 0 0 0 0 0 00 00000000 0
2 4 1 98000000 00 00 0 0 0 00 1 0 0 0 00000000 1 1 0 1 1 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 4 4 00000000 0 0 0 0 0 0 10 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 6 4 00000000 0 0 0 0 0 0 00 00000005 0
0 0 0 00000000 00 00 0 0 0 00 0 0 5 4 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 7 4 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 4 4 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 6 4 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 5 8 ffffffff 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 7 8 ffffffff 0 0 0 0 0 0 00 00000000 1
0 0 0 00000000 00 00 0 0 0 00 0 0 4 0 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 6 0 00000000 0 0 0 0 0 0 00 0000000e 0
0 0 0 00000000 00 00 0 0 0 00 0 0 4 4 00000000 0 0 0 0 0 0 00 00000000 0
0 0 0 00000000 00 00 0 0 0 00 0 0 6 4 00000000 0 0 0 0 0 0 00 00000000 0
